//--- compile.f
src/edge_pkg.sv
src/edge_read_ifs.sv
src/edge_read_request.sv
src/cacheline_memory.sv
src/edge_data_extract.sv
src/edge_data_response.sv
src/edge_data_read_top.sv
dv/edge_data_read_tb.sv

//--- dv/edge_data_read_tb.sv
////////////////////////////////////////////////////////////
// Edge data read path testbench
// Random reads checked against a word model of the memory
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module edge_data_read_tb;

	localparam int LINE_COUNT = 32;
	localparam int RESPONSE_DEPTH = 4;
	localparam int WORD_COUNT = LINE_COUNT * edge_pkg::WORDS_PER_LINE;
	localparam int INDEX_BITS = $clog2(WORD_COUNT);
	localparam int TAG_BITS = edge_pkg::TAG_BITS;
	localparam int DEST_BITS = edge_pkg::DEST_BITS;
	localparam int WAIT_LIMIT = 500;
	localparam int BURST_COUNT = 200;
	localparam int REWRITE_COUNT = 24;

	logic                           clock;
	logic                           rstn;
	logic                           edge_req;
	logic [INDEX_BITS-1:0]          edge_index;
	logic [TAG_BITS-1:0]            edge_tag;
	logic [DEST_BITS-1:0]           edge_dest;
	logic                           edge_ack;
	logic [edge_pkg::WORD_BITS-1:0] data_word;
	logic [TAG_BITS-1:0]            data_tag;
	logic [DEST_BITS-1:0]           data_dest;
	logic                           data_req;
	logic                           data_ack;
	logic                           write_enable;
	logic [INDEX_BITS-1:0]          write_address;
	logic [edge_pkg::WORD_BITS-1:0] write_data;

	// Word model of the memory and responses still owed
	logic [edge_pkg::WORD_BITS-1:0] mem_model [WORD_COUNT];
	logic [edge_pkg::WORD_BITS-1:0] expected_words [$];
	edge_pkg::edge_cmd_t            expected_cmds [$];
	int                             max_ack_wait;

	edge_data_read_top #(
		.LINE_COUNT     (LINE_COUNT),
		.RESPONSE_DEPTH (RESPONSE_DEPTH)
	) uut (
		.clock         (clock),
		.rstn          (rstn),
		.edge_req      (edge_req),
		.edge_index    (edge_index),
		.edge_tag      (edge_tag),
		.edge_dest     (edge_dest),
		.edge_ack      (edge_ack),
		.data_word     (data_word),
		.data_tag      (data_tag),
		.data_dest     (data_dest),
		.data_req      (data_req),
		.data_ack      (data_ack),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data)
	);

	always #10 clock = ~clock;

	// Host sees words with the first memory byte in the low lane
	function automatic logic [edge_pkg::WORD_BITS-1:0] byte_swapped(
		input logic [edge_pkg::WORD_BITS-1:0] word
	);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
		$display("Simulation finished: FAIL");
		$fatal(1, "wait limit reached");
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "control bit mismatch");
		end
	endtask

	task automatic check_word(input string name, input logic [edge_pkg::WORD_BITS-1:0] got,
		input logic [edge_pkg::WORD_BITS-1:0] expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, expected);
			$display("Simulation finished: FAIL");
			$fatal(1, "word mismatch");
		end
	endtask

	// Only tag and dest come back to the host
	task automatic check_cmd(input edge_pkg::edge_cmd_t got, input edge_pkg::edge_cmd_t expected);
		if (got.tag !== expected.tag) begin
			$display("FAIL data_tag: got 0x%h expected 0x%h", got.tag, expected.tag);
			$display("Simulation finished: FAIL");
			$fatal(1, "tag mismatch");
		end else if (got.dest !== expected.dest) begin
			$display("FAIL data_dest: got 0x%h expected 0x%h", got.dest, expected.dest);
			$display("Simulation finished: FAIL");
			$fatal(1, "dest mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////

	task automatic wait_edge_ack(input logic level, output int cycles);
		cycles = 0;
		while (edge_ack !== level) begin
			@(negedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				report_timeout(level ? "edge_ack to rise" : "edge_ack to fall");
			end
		end
	endtask

	task automatic write_word(input logic [INDEX_BITS-1:0] address,
		input logic [edge_pkg::WORD_BITS-1:0] value);
		@(negedge clock);
		write_enable = 1'b1;
		write_address = address;
		write_data = value;
		mem_model[address] = value;
		@(negedge clock);
		write_enable = 1'b0;
	endtask

	task automatic send_request(input logic [INDEX_BITS-1:0] index,
		input logic [TAG_BITS-1:0] tag, input logic [DEST_BITS-1:0] dest);
		int                  waited;
		edge_pkg::edge_cmd_t cmd;
		@(negedge clock);
		edge_req = 1'b1;
		edge_index = index;
		edge_tag = tag;
		edge_dest = dest;
		wait_edge_ack(1'b1, waited);
		if (waited > max_ack_wait) begin
			max_ack_wait = waited;
		end
		// Acked requests are owed a response in this order
		cmd.tag = tag;
		cmd.dest = dest;
		cmd.word_offset = index[edge_pkg::OFFSET_BITS-1:0];
		expected_words.push_back(byte_swapped(mem_model[index]));
		expected_cmds.push_back(cmd);
		edge_req = 1'b0;
		wait_edge_ack(1'b0, waited);
	endtask

	task automatic take_response(input int max_delay);
		int                  waited;
		int                  delay;
		edge_pkg::edge_cmd_t got_cmd;
		waited = 0;
		while (data_req !== 1'b1) begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("data_req to rise");
			end
		end
		if (expected_words.size() == 0) begin
			$display("A response arrived while no request was outstanding");
			$display("Simulation finished: FAIL");
			$fatal(1, "unexpected response");
		end
		got_cmd = '0;
		got_cmd.tag = data_tag;
		got_cmd.dest = data_dest;
		check_word("data_word", data_word, expected_words.pop_front());
		check_cmd(got_cmd, expected_cmds.pop_front());
		// Slow host acks drain the request credits
		delay = int'($urandom_range(max_delay));
		repeat (delay) @(negedge clock);
		data_ack = 1'b1;
		waited = 0;
		while (data_req !== 1'b0) begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("data_req to fall");
			end
		end
		data_ack = 1'b0;
	endtask

	task automatic read_word(input logic [INDEX_BITS-1:0] index);
		send_request(index, TAG_BITS'($urandom()), DEST_BITS'($urandom()));
		take_response(3);
	endtask

	task automatic run_burst(input int count);
		fork
			begin
				for (int n = 0; n < count; n++) begin
					send_request(INDEX_BITS'($urandom_range(WORD_COUNT - 1)),
						TAG_BITS'($urandom()), DEST_BITS'($urandom()));
				end
			end
			begin
				for (int n = 0; n < count; n++) begin
					take_response(24);
				end
			end
		join
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int                    line;
		logic [INDEX_BITS-1:0] rewritten [REWRITE_COUNT];
		clock = 1'b0;
		rstn = 1'b0;
		edge_req = 1'b0;
		edge_index = '0;
		edge_tag = '0;
		edge_dest = '0;
		data_ack = 1'b0;
		write_enable = 1'b0;
		write_address = '0;
		write_data = '0;
		max_ack_wait = 0;
		for (int i = 0; i < WORD_COUNT; i++) begin
			mem_model[i] = '0;
		end
		void'($urandom(32'hc7b6));

		repeat (16) @(negedge clock);
		rstn = 1'b1;

		// Idle outputs before any request
		repeat (4) @(negedge clock);
		check_bit("edge_ack", edge_ack, 1'b0);
		check_bit("data_req", data_req, 1'b0);

		for (int i = 0; i < WORD_COUNT; i++) begin
			write_word(INDEX_BITS'(i), $urandom());
		end

		for (int n = 0; n < 40; n++) begin
			read_word(INDEX_BITS'($urandom_range(WORD_COUNT - 1)));
		end

		// Words at both ends of each half line
		for (int n = 0; n < 8; n++) begin
			line = int'($urandom_range(LINE_COUNT - 1));
			read_word(INDEX_BITS'(line * edge_pkg::WORDS_PER_LINE));
			read_word(INDEX_BITS'(line * edge_pkg::WORDS_PER_LINE + 7));
			read_word(INDEX_BITS'(line * edge_pkg::WORDS_PER_LINE + 8));
			read_word(INDEX_BITS'(line * edge_pkg::WORDS_PER_LINE + 15));
		end

		max_ack_wait = 0;
		run_burst(BURST_COUNT);
		if (max_ack_wait <= 4) begin
			$display("The burst never ran out of credits, edge_ack did not stall");
			$display("Simulation finished: FAIL");
			$fatal(1, "no credit stall");
		end

		// Overwritten words read back at the same addresses
		for (int n = 0; n < REWRITE_COUNT; n++) begin
			rewritten[n] = INDEX_BITS'($urandom_range(WORD_COUNT - 1));
			write_word(rewritten[n], $urandom());
		end
		for (int n = 0; n < REWRITE_COUNT; n++) begin
			read_word(rewritten[n]);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the edge data read path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module edge_data_read_tb -o edge_data_read_sim

# The log decides the result
./obj_dir/edge_data_read_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Simulation run failed"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation run passed"

//--- src/cacheline_memory.sv
////////////////////////////////////////////////////////////
// Two-bank cacheline store
// Word writes, half line reads returned one cycle apart
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cacheline_memory #(
	parameter int LINE_COUNT = 32,
	localparam int INDEX_BITS = $clog2(LINE_COUNT * edge_pkg::WORDS_PER_LINE),
	localparam int ADDR_BITS = $clog2(LINE_COUNT)
) (
	input  logic                           clock,
	input  logic                           rstn,
	read_cmd_if.sink                       read_cmd,
	input  logic                           write_enable,
	input  logic [INDEX_BITS-1:0]          write_address,
	input  logic [edge_pkg::WORD_BITS-1:0] write_data,
	half_line_if.source                    half_0,
	half_line_if.source                    half_1
);

	logic [edge_pkg::HALF_LINE_BITS-1:0] bank_0 [LINE_COUNT];
	logic [edge_pkg::HALF_LINE_BITS-1:0] bank_1 [LINE_COUNT];

	logic [ADDR_BITS-1:0]          write_line;
	logic                          write_bank;
	logic [edge_pkg::SLOT_BITS-1:0] write_slot;

	logic                                stage_valid;
	edge_pkg::edge_cmd_t                 stage_cmd;
	logic [edge_pkg::HALF_LINE_BITS-1:0] stage_data;

	////////////////////////////////////////////////////////////
	// Word write port
	////////////////////////////////////////////////////////////

	// Offset bit 3 selects the bank, the low bits the slot
	assign write_line = write_address[INDEX_BITS-1:edge_pkg::OFFSET_BITS];
	assign write_bank = write_address[edge_pkg::OFFSET_BITS-1];
	assign write_slot = write_address[edge_pkg::SLOT_BITS-1:0];

	// Empty memory at power up
	initial begin
		for (int i = 0; i < LINE_COUNT; i++) begin
			bank_0[i] = '0;
			bank_1[i] = '0;
		end
	end

	always @(posedge clock) begin
		if (write_enable) begin
			if (write_bank) begin
				bank_1[write_line][write_slot*edge_pkg::WORD_BITS +: edge_pkg::WORD_BITS] <=
					write_data;
			end else begin
				bank_0[write_line][write_slot*edge_pkg::WORD_BITS +: edge_pkg::WORD_BITS] <=
					write_data;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read return with bank 1 one cycle ahead of bank 0
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			half_1.valid <= 1'b0;
			stage_valid <= 1'b0;
			half_0.valid <= 1'b0;
		end else begin
			half_1.valid <= read_cmd.valid;
			stage_valid <= read_cmd.valid;
			half_0.valid <= stage_valid;
		end
	end

	always_ff @(posedge clock) begin
		half_1.data <= bank_1[read_cmd.line_address];
		half_1.cmd <= read_cmd.cmd;
		stage_data <= bank_0[read_cmd.line_address];
		stage_cmd <= read_cmd.cmd;
		half_0.data <= stage_data;
		half_0.cmd <= stage_cmd;
	end

endmodule

//--- src/edge_data_extract.sv
////////////////////////////////////////////////////////////
// Edge data extract
// Aligns the two halves, picks the word, reverses its bytes
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module edge_data_extract (
	input  logic                           clock,
	input  logic                           rstn,
	half_line_if.sink                      half_0,
	half_line_if.sink                      half_1,
	output logic                           result_valid,
	output logic [edge_pkg::WORD_BITS-1:0] result_word,
	output edge_pkg::edge_cmd_t            result_cmd
);

	// Half 1 held back one cycle
	logic                                h1_valid;
	edge_pkg::edge_cmd_t                 h1_cmd;
	logic [edge_pkg::HALF_LINE_BITS-1:0] h1_data;

	// Joined line
	logic                                line_valid;
	edge_pkg::edge_cmd_t                 line_cmd;
	logic [edge_pkg::HALF_LINE_BITS-1:0] line_lo;
	logic [edge_pkg::HALF_LINE_BITS-1:0] line_hi;

	// Selected word, still in memory byte order
	logic                           word_valid;
	edge_pkg::edge_cmd_t            word_cmd;
	logic [edge_pkg::WORD_BITS-1:0] word_data;

	logic [edge_pkg::SLOT_BITS-1:0] select_slot;
	logic                           select_high;

	function automatic logic [edge_pkg::WORD_BITS-1:0] reverse_bytes(
		input logic [edge_pkg::WORD_BITS-1:0] word
	);
		logic [edge_pkg::WORD_BITS-1:0] swapped;
		for (int b = 0; b < edge_pkg::WORD_BITS / 8; b++) begin
			swapped[8*b +: 8] = word[edge_pkg::WORD_BITS - 8*(b+1) +: 8];
		end
		return swapped;
	endfunction

	////////////////////////////////////////////////////////////
	// Valid pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			h1_valid <= 1'b0;
			line_valid <= 1'b0;
			word_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			h1_valid <= half_1.valid;
			line_valid <= half_0.valid;
			word_valid <= line_valid;
			result_valid <= word_valid;
		end
	end

	////////////////////////////////////////////////////////////
	// Payload pipeline
	////////////////////////////////////////////////////////////

	// Offsets 8 to 15 live in the upper half
	assign select_slot = line_cmd.word_offset[edge_pkg::SLOT_BITS-1:0];
	assign select_high = line_cmd.word_offset[edge_pkg::OFFSET_BITS-1];

	always_ff @(posedge clock) begin
		h1_data <= half_1.data;
		h1_cmd <= half_1.cmd;

		// Stage 1 joins the halves
		line_lo <= half_0.data;
		line_hi <= h1_data;
		line_cmd <= half_0.cmd;

		// Stage 2 selects the word
		if (select_high) begin
			word_data <= line_hi[select_slot*edge_pkg::WORD_BITS +: edge_pkg::WORD_BITS];
		end else begin
			word_data <= line_lo[select_slot*edge_pkg::WORD_BITS +: edge_pkg::WORD_BITS];
		end
		word_cmd <= line_cmd;

		// Stage 3 reverses the byte order
		result_word <= reverse_bytes(word_data);
		result_cmd <= word_cmd;
	end

	// Memory skew must line up both halves of the same read
	half_alignment: assert property (@(posedge clock) disable iff (!rstn)
		(half_0.valid == h1_valid) && (!half_0.valid || half_0.cmd == h1_cmd))
		else $error("half line 0 and delayed half line 1 are misaligned");

endmodule

//--- src/edge_data_read_top.sv
////////////////////////////////////////////////////////////
// Edge data read path top level
// Request, memory, extract and response stages
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module edge_data_read_top #(
	parameter int LINE_COUNT = 32,
	parameter int RESPONSE_DEPTH = 4,
	localparam int INDEX_BITS = $clog2(LINE_COUNT * edge_pkg::WORDS_PER_LINE)
) (
	input  logic                           clock,
	input  logic                           rstn,
	// Request side
	input  logic                           edge_req,
	input  logic [INDEX_BITS-1:0]          edge_index,
	input  logic [edge_pkg::TAG_BITS-1:0]  edge_tag,
	input  logic [edge_pkg::DEST_BITS-1:0] edge_dest,
	output logic                           edge_ack,
	// Response side
	output logic [edge_pkg::WORD_BITS-1:0] data_word,
	output logic [edge_pkg::TAG_BITS-1:0]  data_tag,
	output logic [edge_pkg::DEST_BITS-1:0] data_dest,
	output logic                           data_req,
	input  logic                           data_ack,
	// Preload port, word addressed
	input  logic                           write_enable,
	input  logic [INDEX_BITS-1:0]          write_address,
	input  logic [edge_pkg::WORD_BITS-1:0] write_data
);

	read_cmd_if #(.LINE_COUNT(LINE_COUNT)) read_cmd ();
	half_line_if half_0 ();
	half_line_if half_1 ();

	logic                           response_done;
	logic                           result_valid;
	logic [edge_pkg::WORD_BITS-1:0] result_word;
	edge_pkg::edge_cmd_t            result_cmd;

	edge_read_request #(
		.LINE_COUNT     (LINE_COUNT),
		.RESPONSE_DEPTH (RESPONSE_DEPTH)
	) request (
		.clock         (clock),
		.rstn          (rstn),
		.edge_req      (edge_req),
		.edge_index    (edge_index),
		.edge_tag      (edge_tag),
		.edge_dest     (edge_dest),
		.edge_ack      (edge_ack),
		.response_done (response_done),
		.read_cmd      (read_cmd.source)
	);

	cacheline_memory #(
		.LINE_COUNT (LINE_COUNT)
	) memory (
		.clock         (clock),
		.rstn          (rstn),
		.read_cmd      (read_cmd.sink),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.half_0        (half_0.source),
		.half_1        (half_1.source)
	);

	edge_data_extract extract (
		.clock        (clock),
		.rstn         (rstn),
		.half_0       (half_0.sink),
		.half_1       (half_1.sink),
		.result_valid (result_valid),
		.result_word  (result_word),
		.result_cmd   (result_cmd)
	);

	edge_data_response #(
		.RESPONSE_DEPTH (RESPONSE_DEPTH)
	) response (
		.clock         (clock),
		.rstn          (rstn),
		.result_valid  (result_valid),
		.result_word   (result_word),
		.result_cmd    (result_cmd),
		.data_req      (data_req),
		.data_ack      (data_ack),
		.data_word     (data_word),
		.data_tag      (data_tag),
		.data_dest     (data_dest),
		.response_done (response_done)
	);

endmodule

//--- src/edge_data_response.sv
////////////////////////////////////////////////////////////
// Edge data response stage
// Result queue and four-phase response handshake
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module edge_data_response #(
	parameter int RESPONSE_DEPTH = 4
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           result_valid,
	input  logic [edge_pkg::WORD_BITS-1:0] result_word,
	input  edge_pkg::edge_cmd_t            result_cmd,
	output logic                           data_req,
	input  logic                           data_ack,
	output logic [edge_pkg::WORD_BITS-1:0] data_word,
	output logic [edge_pkg::TAG_BITS-1:0]  data_tag,
	output logic [edge_pkg::DEST_BITS-1:0] data_dest,
	output logic                           response_done
);

	localparam int PTR_BITS = (RESPONSE_DEPTH > 1) ? $clog2(RESPONSE_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(RESPONSE_DEPTH + 1);

	logic [edge_pkg::WORD_BITS-1:0] word_q [RESPONSE_DEPTH];
	edge_pkg::edge_cmd_t            cmd_q [RESPONSE_DEPTH];

	logic [PTR_BITS-1:0]       wr_ptr;
	logic [PTR_BITS-1:0]       rd_ptr;
	logic [COUNT_BITS-1:0]     count;
	logic                      pop;
	edge_pkg::response_state_t state;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(RESPONSE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Result queue
	////////////////////////////////////////////////////////////

	// Head leaves once the host has dropped its ack
	assign pop = (state == edge_pkg::resp_wait_release) && !data_ack;

	always_ff @(posedge clock) begin
		if (result_valid) begin
			word_q[wr_ptr] <= result_word;
			cmd_q[wr_ptr] <= result_cmd;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (result_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + COUNT_BITS'(result_valid) - COUNT_BITS'(pop);
		end
	end

	assign data_word = word_q[rd_ptr];
	assign data_tag = cmd_q[rd_ptr].tag;
	assign data_dest = cmd_q[rd_ptr].dest;

	////////////////////////////////////////////////////////////
	// Response handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= edge_pkg::resp_idle;
			data_req <= 1'b0;
			response_done <= 1'b0;
		end else begin
			response_done <= pop;
			case (state)
				edge_pkg::resp_idle: begin
					// Incoming result lands in the queue on this same edge
					if (count != '0 || result_valid) begin
						data_req <= 1'b1;
						state <= edge_pkg::resp_wait_ack;
					end
				end
				edge_pkg::resp_wait_ack: begin
					if (data_ack) begin
						data_req <= 1'b0;
						state <= edge_pkg::resp_wait_release;
					end
				end
				edge_pkg::resp_wait_release: begin
					if (!data_ack) begin
						state <= edge_pkg::resp_idle;
					end
				end
				default: begin
					state <= edge_pkg::resp_idle;
				end
			endcase
		end
	end

	// Request side credits keep the queue from overflowing
	no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		result_valid |-> (count < COUNT_BITS'(RESPONSE_DEPTH)))
		else $error("result arrived at a full response queue");

endmodule

//--- src/edge_pkg.sv
////////////////////////////////////////////////////////////
// Edge data read path shared definitions
// Line and word geometry, read command and FSM states
////////////////////////////////////////////////////////////

package edge_pkg;

	////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////

	parameter int WORD_BITS = 32;
	parameter int HALF_LINE_BITS = 256;
	parameter int WORDS_PER_HALF = HALF_LINE_BITS / WORD_BITS;
	parameter int WORDS_PER_LINE = 2 * WORDS_PER_HALF;

	// Word offset inside a full line
	parameter int OFFSET_BITS = $clog2(WORDS_PER_LINE);

	// Word slot inside one half line
	parameter int SLOT_BITS = $clog2(WORDS_PER_HALF);

	////////////////////////////////////////////////////////////
	// Request fields
	////////////////////////////////////////////////////////////

	parameter int TAG_BITS = 4;
	parameter int DEST_BITS = 16;

	// Travels alongside every read through the pipeline
	typedef struct packed {
		logic [TAG_BITS-1:0]    tag;
		logic [DEST_BITS-1:0]   dest;
		logic [OFFSET_BITS-1:0] word_offset;
	} edge_cmd_t;

	////////////////////////////////////////////////////////////
	// FSM states
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		req_idle,
		req_acked,
		req_release
	} request_state_t;

	typedef enum logic [1:0] {
		resp_idle,
		resp_wait_ack,
		resp_wait_release
	} response_state_t;

endpackage

//--- src/edge_read_ifs.sv
////////////////////////////////////////////////////////////
// Read command and half line interfaces
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

// Cacheline read issued by the request stage
interface read_cmd_if #(
	parameter int LINE_COUNT = 32
);
	logic                      valid;
	logic [$clog2(LINE_COUNT)-1:0] line_address;
	edge_pkg::edge_cmd_t       cmd;

	modport source (output valid, output line_address, output cmd);
	modport sink (input valid, input line_address, input cmd);
endinterface

// One half of a returned cacheline
interface half_line_if;
	logic                                valid;
	edge_pkg::edge_cmd_t                 cmd;
	logic [edge_pkg::HALF_LINE_BITS-1:0] data;

	modport source (output valid, output cmd, output data);
	modport sink (input valid, input cmd, input data);
endinterface

//--- src/edge_read_request.sv
////////////////////////////////////////////////////////////
// Edge read request stage
// Four-phase intake, index split and credit based issue
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module edge_read_request #(
	parameter int LINE_COUNT = 32,
	parameter int RESPONSE_DEPTH = 4,
	localparam int INDEX_BITS = $clog2(LINE_COUNT * edge_pkg::WORDS_PER_LINE)
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           edge_req,
	input  logic [INDEX_BITS-1:0]          edge_index,
	input  logic [edge_pkg::TAG_BITS-1:0]  edge_tag,
	input  logic [edge_pkg::DEST_BITS-1:0] edge_dest,
	output logic                           edge_ack,
	input  logic                           response_done,
	read_cmd_if.source                     read_cmd
);

	localparam int CREDIT_BITS = $clog2(RESPONSE_DEPTH + 1);

	edge_pkg::request_state_t state;
	logic [CREDIT_BITS-1:0]   credits;
	logic                     issue;

	// New request only from idle and with a free response slot
	assign issue = (state == edge_pkg::req_idle) && edge_req && (credits != '0);

	////////////////////////////////////////////////////////////
	// Intake handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= edge_pkg::req_idle;
			edge_ack <= 1'b0;
		end else begin
			case (state)
				edge_pkg::req_idle: begin
					if (issue) begin
						edge_ack <= 1'b1;
						state <= edge_pkg::req_acked;
					end
				end
				edge_pkg::req_acked: begin
					// Host releases its request, so drop ack
					if (!edge_req) begin
						edge_ack <= 1'b0;
						state <= edge_pkg::req_release;
					end
				end
				edge_pkg::req_release: begin
					state <= edge_pkg::req_idle;
				end
				default: begin
					state <= edge_pkg::req_idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read command issue
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd.valid <= 1'b0;
		end else begin
			read_cmd.valid <= issue;
		end
	end

	// Upper index bits pick the line, lower bits the word
	always_ff @(posedge clock) begin
		if (issue) begin
			read_cmd.line_address <= edge_index[INDEX_BITS-1:edge_pkg::OFFSET_BITS];
			read_cmd.cmd.tag <= edge_tag;
			read_cmd.cmd.dest <= edge_dest;
			read_cmd.cmd.word_offset <= edge_index[edge_pkg::OFFSET_BITS-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Credits
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= CREDIT_BITS'(RESPONSE_DEPTH);
		end else begin
			case ({issue, response_done})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Responses may never return more credits than were spent
	credit_bound: assert property (@(posedge clock) disable iff (!rstn)
		credits <= CREDIT_BITS'(RESPONSE_DEPTH))
		else $error("request credits exceed response queue depth");

endmodule
